// File: source/perturb_pkg.sv
// Memory-port perturbation subsystem shared definitions
// Bus widths, stall limits, LFSR constants and register map

package perturb_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = 4;

    ////////////////////////////////////////////////////////////
    // Stall and response limits
    ////////////////////////////////////////////////////////////

    // Width of every stall count and of the random maximum
    localparam int unsigned STALL_W    = 8;
    // Response slots, also the cap on outstanding transfers
    // Kept a power of two so the FIFO pointers wrap by themselves
    localparam int unsigned RESP_DEPTH = 4;
    localparam int unsigned RESP_PTR_W = $clog2(RESP_DEPTH);
    localparam int unsigned RESP_CNT_W = $clog2(RESP_DEPTH + 1);

    // Random source
    localparam int unsigned LFSR_W = 16;
    // x^16 + x^14 + x^13 + x^11 + 1, right-shifting Galois form
    localparam logic [LFSR_W-1:0] LFSR_TAPS  = 16'hB400;
    localparam logic [LFSR_W-1:0] LFSR_RESET = 16'h0001;

    ////////////////////////////////////////////////////////////
    // Configuration register map
    ////////////////////////////////////////////////////////////

    localparam int unsigned CFG_ADDR_W = 3;

    typedef enum logic {
        STALL_FIXED  = 1'b0,
        STALL_RANDOM = 1'b1
    } stall_mode_e;

    // CFG_CTRL holds enable in bit 0 and mode in bit 1
    typedef enum logic [CFG_ADDR_W-1:0] {
        CFG_CTRL   = 3'd0,
        CFG_GNT    = 3'd1,
        CFG_RVALID = 3'd2,
        CFG_MAX    = 3'd3,
        CFG_SEED   = 3'd4
    } cfg_reg_e;

endpackage

// File: source/stall_cfg_regs.sv
// Stall configuration registers
// Holds enable, mode, stall counts, random maximum and LFSR seed

module stall_cfg_regs (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                cfg_we_i,
    input  logic [perturb_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [perturb_pkg::DATA_W-1:0]     cfg_wdata_i,
    output logic [perturb_pkg::DATA_W-1:0]     cfg_rdata_o,
    output logic                                stall_en_o,
    output perturb_pkg::stall_mode_e            stall_mode_o,
    output logic [perturb_pkg::STALL_W-1:0]    gnt_stall_o,
    output logic [perturb_pkg::STALL_W-1:0]    rvalid_stall_o,
    output logic [perturb_pkg::STALL_W-1:0]    max_stall_o,
    output logic                                seed_load_o,
    output logic [perturb_pkg::LFSR_W-1:0]     seed_o
);

    // Register write decode, effective the cycle after the write strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stall_en_o     <= 1'b0;
            stall_mode_o   <= perturb_pkg::STALL_FIXED;
            gnt_stall_o    <= '0;
            rvalid_stall_o <= '0;
            max_stall_o    <= '0;
            seed_o         <= '0;
            seed_load_o    <= 1'b0;
        end else begin
            // Seed load strobe lasts exactly one cycle
            seed_load_o <= 1'b0;
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    perturb_pkg::CFG_CTRL: begin
                        stall_en_o   <= cfg_wdata_i[0];
                        stall_mode_o <= perturb_pkg::stall_mode_e'(cfg_wdata_i[1]);
                    end
                    perturb_pkg::CFG_GNT:    gnt_stall_o    <= cfg_wdata_i[perturb_pkg::STALL_W-1:0];
                    perturb_pkg::CFG_RVALID: rvalid_stall_o <= cfg_wdata_i[perturb_pkg::STALL_W-1:0];
                    perturb_pkg::CFG_MAX:    max_stall_o    <= cfg_wdata_i[perturb_pkg::STALL_W-1:0];
                    perturb_pkg::CFG_SEED: begin
                        seed_o      <= cfg_wdata_i[perturb_pkg::LFSR_W-1:0];
                        seed_load_o <= 1'b1;
                    end
                    // Unmapped addresses drop the write
                    default: ;
                endcase
            end
        end
    end

    // Combinational readback, zero extended, unmapped reads zero
    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            perturb_pkg::CFG_CTRL: begin
                cfg_rdata_o[0] = stall_en_o;
                cfg_rdata_o[1] = stall_mode_o;
            end
            perturb_pkg::CFG_GNT:    cfg_rdata_o[perturb_pkg::STALL_W-1:0] = gnt_stall_o;
            perturb_pkg::CFG_RVALID: cfg_rdata_o[perturb_pkg::STALL_W-1:0] = rvalid_stall_o;
            perturb_pkg::CFG_MAX:    cfg_rdata_o[perturb_pkg::STALL_W-1:0] = max_stall_o;
            perturb_pkg::CFG_SEED:   cfg_rdata_o[perturb_pkg::LFSR_W-1:0]  = seed_o;
            default: ;
        endcase
    end

endmodule

// File: source/stall_lfsr.sv
// Random stall source
// 16-bit maximal-length Galois LFSR, one step per drawn stall

module stall_lfsr (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            step_i,
    input  logic                            load_i,
    input  logic [perturb_pkg::LFSR_W-1:0] seed_i,
    output logic [perturb_pkg::LFSR_W-1:0] value_o
);

    logic [perturb_pkg::LFSR_W-1:0] value_q;
    logic [perturb_pkg::LFSR_W-1:0] value_next;

    // Shift right, fold the taps in when a one drops out
    always_comb begin
        value_next = {1'b0, value_q[perturb_pkg::LFSR_W-1:1]};
        if (value_q[0]) begin
            value_next = value_next ^ perturb_pkg::LFSR_TAPS;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            value_q <= perturb_pkg::LFSR_RESET;
        end else if (load_i) begin
            // All-zero state would lock up, substitute one
            value_q <= (seed_i == '0) ? perturb_pkg::LFSR_RESET : seed_i;
        end else if (step_i) begin
            value_q <= value_next;
        end
    end

    assign value_o = value_q;

endmodule

// File: source/stall_injector.sv
// Data port stall injector
// Holds back grants, buffers memory responses and releases them
// after a drawn stall, limiting transfers in flight to RESP_DEPTH

module stall_injector (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Core side
    input  logic                            core_req_i,
    input  logic [perturb_pkg::ADDR_W-1:0] core_addr_i,
    input  logic                            core_we_i,
    input  logic [perturb_pkg::BE_W-1:0]   core_be_i,
    input  logic [perturb_pkg::DATA_W-1:0] core_wdata_i,
    output logic                            core_gnt_o,
    output logic                            core_rvalid_o,
    output logic [perturb_pkg::DATA_W-1:0] core_rdata_o,
    // Memory side
    output logic                            mem_req_o,
    output logic [perturb_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                            mem_we_o,
    output logic [perturb_pkg::BE_W-1:0]   mem_be_o,
    output logic [perturb_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic                            mem_gnt_i,
    input  logic                            mem_rvalid_i,
    input  logic [perturb_pkg::DATA_W-1:0] mem_rdata_i,
    // Configuration and random source
    input  logic                            stall_en_i,
    input  perturb_pkg::stall_mode_e        stall_mode_i,
    input  logic [perturb_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] rvalid_stall_i,
    input  logic [perturb_pkg::STALL_W-1:0] max_stall_i,
    input  logic [perturb_pkg::LFSR_W-1:0] rand_i,
    output logic                            draw_o
);

    typedef enum logic { GNT_IDLE, GNT_WAIT } gnt_state_e;
    typedef enum logic { RSP_IDLE, RSP_WAIT } rsp_state_e;

    logic [perturb_pkg::STALL_W-1:0]    rand_clamped;
    logic [perturb_pkg::STALL_W-1:0]    gnt_draw;
    logic [perturb_pkg::STALL_W-1:0]    rsp_draw;
    gnt_state_e                         gnt_state_q;
    logic [perturb_pkg::STALL_W-1:0]    gnt_cnt_q;
    logic                               gnt_new;
    logic                               gnt_open;
    logic                               slot_free;
    logic [perturb_pkg::RESP_CNT_W-1:0] out_cnt_q;
    logic [perturb_pkg::DATA_W-1:0]     fifo_mem_q [perturb_pkg::RESP_DEPTH];
    logic [perturb_pkg::RESP_PTR_W-1:0] fifo_wr_ptr_q;
    logic [perturb_pkg::RESP_PTR_W-1:0] fifo_rd_ptr_q;
    logic [perturb_pkg::RESP_CNT_W-1:0] fifo_cnt_q;
    rsp_state_e                         rsp_state_q;
    logic [perturb_pkg::STALL_W-1:0]    rsp_cnt_q;
    logic                               rsp_new;

    ////////////////////////////////////////////////////////////
    // Stall draw
    ////////////////////////////////////////////////////////////

    // Both paths share one LFSR value, so a joint draw steps it once
    always_comb begin
        rand_clamped = rand_i[perturb_pkg::STALL_W-1:0];
        if (rand_clamped > max_stall_i) begin
            rand_clamped = max_stall_i;
        end
        if (!stall_en_i) begin
            gnt_draw = '0;
            rsp_draw = '0;
        end else if (stall_mode_i == perturb_pkg::STALL_FIXED) begin
            gnt_draw = gnt_stall_i;
            rsp_draw = rvalid_stall_i;
        end else begin
            gnt_draw = rand_clamped;
            rsp_draw = rand_clamped;
        end
    end

    assign draw_o = gnt_new || rsp_new;

    ////////////////////////////////////////////////////////////
    // Grant path
    ////////////////////////////////////////////////////////////

    // New request when idle, the draw cycle itself counts as a stall cycle
    assign gnt_new   = (gnt_state_q == GNT_IDLE) && core_req_i;
    assign gnt_open  = (gnt_state_q == GNT_IDLE) ? (gnt_draw == '0) : (gnt_cnt_q == '0);
    // No new grant while every response slot is claimed
    assign slot_free = out_cnt_q < perturb_pkg::RESP_DEPTH;

    assign mem_req_o  = core_req_i && gnt_open && slot_free;
    assign core_gnt_o = mem_req_o && mem_gnt_i;

    // Request fields go straight to memory
    assign mem_addr_o  = core_addr_i;
    assign mem_we_o    = core_we_i;
    assign mem_be_o    = core_be_i;
    assign mem_wdata_o = core_wdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gnt_state_q <= GNT_IDLE;
            gnt_cnt_q   <= '0;
        end else begin
            case (gnt_state_q)
                GNT_IDLE: begin
                    if (gnt_new && !core_gnt_o) begin
                        gnt_state_q <= GNT_WAIT;
                        // One less, the draw cycle already stalled once
                        gnt_cnt_q   <= (gnt_draw == '0) ? '0 : gnt_draw - 1'b1;
                    end
                end
                GNT_WAIT: begin
                    if (gnt_cnt_q != '0) begin
                        gnt_cnt_q <= gnt_cnt_q - 1'b1;
                    end else if (core_gnt_o) begin
                        gnt_state_q <= GNT_IDLE;
                    end
                end
                default: gnt_state_q <= GNT_IDLE;
            endcase
        end
    end

    // Transfers granted but not yet answered to the core
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_cnt_q <= '0;
        end else begin
            case ({core_gnt_o, core_rvalid_o})
                2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
                2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////

    // Head draws once on arrival, zero stall releases at once
    assign rsp_new       = (rsp_state_q == RSP_IDLE) && (fifo_cnt_q != '0);
    assign core_rvalid_o = (rsp_state_q == RSP_IDLE) ? (rsp_new && (rsp_draw == '0))
                                                     : (rsp_cnt_q == '0);
    assign core_rdata_o  = fifo_mem_q[fifo_rd_ptr_q];

    // Response data storage
    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            fifo_mem_q[fifo_wr_ptr_q] <= mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fifo_wr_ptr_q <= '0;
            fifo_rd_ptr_q <= '0;
            fifo_cnt_q    <= '0;
        end else begin
            if (mem_rvalid_i) begin
                fifo_wr_ptr_q <= fifo_wr_ptr_q + 1'b1;
            end
            if (core_rvalid_o) begin
                fifo_rd_ptr_q <= fifo_rd_ptr_q + 1'b1;
            end
            case ({mem_rvalid_i, core_rvalid_o})
                2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
                2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_state_q <= RSP_IDLE;
            rsp_cnt_q   <= '0;
        end else begin
            case (rsp_state_q)
                RSP_IDLE: begin
                    if (rsp_new && (rsp_draw != '0)) begin
                        rsp_state_q <= RSP_WAIT;
                        rsp_cnt_q   <= rsp_draw - 1'b1;
                    end
                end
                RSP_WAIT: begin
                    if (rsp_cnt_q != '0) begin
                        rsp_cnt_q <= rsp_cnt_q - 1'b1;
                    end else begin
                        // Head leaves this cycle
                        rsp_state_q <= RSP_IDLE;
                    end
                end
                default: rsp_state_q <= RSP_IDLE;
            endcase
        end
    end

endmodule

// File: source/perturb_top.sv
// Memory-port perturbation subsystem top level
// Register block, random source and stall injector on the data port

module perturb_top (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // Core side
    input  logic                                core_req_i,
    input  logic [perturb_pkg::ADDR_W-1:0]     core_addr_i,
    input  logic                                core_we_i,
    input  logic [perturb_pkg::BE_W-1:0]       core_be_i,
    input  logic [perturb_pkg::DATA_W-1:0]     core_wdata_i,
    output logic                                core_gnt_o,
    output logic                                core_rvalid_o,
    output logic [perturb_pkg::DATA_W-1:0]     core_rdata_o,
    // Memory side
    output logic                                mem_req_o,
    output logic [perturb_pkg::ADDR_W-1:0]     mem_addr_o,
    output logic                                mem_we_o,
    output logic [perturb_pkg::BE_W-1:0]       mem_be_o,
    output logic [perturb_pkg::DATA_W-1:0]     mem_wdata_o,
    input  logic                                mem_gnt_i,
    input  logic                                mem_rvalid_i,
    input  logic [perturb_pkg::DATA_W-1:0]     mem_rdata_i,
    // Register port
    input  logic                                cfg_we_i,
    input  logic [perturb_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
    input  logic [perturb_pkg::DATA_W-1:0]     cfg_wdata_i,
    output logic [perturb_pkg::DATA_W-1:0]     cfg_rdata_o
);

    logic                            stall_en;
    perturb_pkg::stall_mode_e        stall_mode;
    logic [perturb_pkg::STALL_W-1:0] gnt_stall;
    logic [perturb_pkg::STALL_W-1:0] rvalid_stall;
    logic [perturb_pkg::STALL_W-1:0] max_stall;
    logic                            seed_load;
    logic [perturb_pkg::LFSR_W-1:0]  seed;
    logic [perturb_pkg::LFSR_W-1:0]  lfsr_value;
    logic                            draw;

    stall_cfg_regs u_cfg_regs (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o),
        .stall_en_o(stall_en), .stall_mode_o(stall_mode),
        .gnt_stall_o(gnt_stall), .rvalid_stall_o(rvalid_stall),
        .max_stall_o(max_stall), .seed_load_o(seed_load), .seed_o(seed)
    );

    // Steps only when the injector draws a stall
    stall_lfsr u_lfsr (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .step_i(draw), .load_i(seed_load), .seed_i(seed), .value_o(lfsr_value)
    );

    stall_injector u_injector (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .core_req_i(core_req_i), .core_addr_i(core_addr_i), .core_we_i(core_we_i),
        .core_be_i(core_be_i), .core_wdata_i(core_wdata_i), .core_gnt_o(core_gnt_o),
        .core_rvalid_o(core_rvalid_o), .core_rdata_o(core_rdata_o),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_we_o(mem_we_o),
        .mem_be_o(mem_be_o), .mem_wdata_o(mem_wdata_o), .mem_gnt_i(mem_gnt_i),
        .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
        .stall_en_i(stall_en), .stall_mode_i(stall_mode), .gnt_stall_i(gnt_stall),
        .rvalid_stall_i(rvalid_stall), .max_stall_i(max_stall),
        .rand_i(lfsr_value), .draw_o(draw)
    );

endmodule

// File: test/perturb_sva.sv
// Protocol assertions for the stall injector
// Grant, outstanding count and stall counter rules

module perturb_sva (
    input logic                                 clk_i,
    input logic                                 rst_n_i,
    input logic                                 core_gnt_i,
    input logic                                 core_rvalid_i,
    input logic                                 mem_req_i,
    input logic [perturb_pkg::RESP_CNT_W-1:0]  out_cnt_i,
    input logic [perturb_pkg::STALL_W-1:0]     gnt_cnt_i
);

    // A core grant is always a memory grant
    gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_gnt_i |-> mem_req_i)
        else $error("core_gnt_o high without mem_req_o");

    rvalid_has_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_rvalid_i |-> (out_cnt_i != '0))
        else $error("core_rvalid_o with no outstanding transfer");

    out_cnt_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_cnt_i <= perturb_pkg::RESP_DEPTH)
        else $error("outstanding count above RESP_DEPTH");

    // Running grant stall keeps memory request low
    stall_blocks_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (gnt_cnt_i != '0) |-> !mem_req_i)
        else $error("mem_req_o high during grant stall");

endmodule

bind stall_injector perturb_sva u_sva (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .core_gnt_i(core_gnt_o),
    .core_rvalid_i(core_rvalid_o), .mem_req_i(mem_req_o),
    .out_cnt_i(out_cnt_q), .gnt_cnt_i(gnt_cnt_q)
);

// File: test/tb_perturb.sv
// Testbench for the memory-port perturbation subsystem
// Random traffic against a memory model and an in-order scoreboard

module tb_perturb;

    logic                                clk_i;
    logic                                rst_n_i;
    logic                                core_req_i;
    logic [perturb_pkg::ADDR_W-1:0]     core_addr_i;
    logic                                core_we_i;
    logic [perturb_pkg::BE_W-1:0]       core_be_i;
    logic [perturb_pkg::DATA_W-1:0]     core_wdata_i;
    logic                                core_gnt_o;
    logic                                core_rvalid_o;
    logic [perturb_pkg::DATA_W-1:0]     core_rdata_o;
    logic                                mem_req_o;
    logic [perturb_pkg::ADDR_W-1:0]     mem_addr_o;
    logic                                mem_we_o;
    logic [perturb_pkg::BE_W-1:0]       mem_be_o;
    logic [perturb_pkg::DATA_W-1:0]     mem_wdata_o;
    logic                                mem_gnt_i;
    logic                                mem_rvalid_i;
    logic [perturb_pkg::DATA_W-1:0]     mem_rdata_i;
    logic                                cfg_we_i;
    logic [perturb_pkg::CFG_ADDR_W-1:0] cfg_addr_i;
    logic [perturb_pkg::DATA_W-1:0]     cfg_wdata_i;
    logic [perturb_pkg::DATA_W-1:0]     cfg_rdata_o;

    // One random stream for stimulus and memory latencies
    logic [31:0] stim_rng = 32'd87;
    int          wait_limit = 500;
    int          tests;
    int          checks;
    int          errors;

    // Memory model storage, pending read data and per-response latency
    logic [31:0] mem [16];
    logic [31:0] mrsp_q [$];
    int          mwait_q [$];
    int          gnt_wait;
    int          gnt_lat_max;
    int          rsp_lat_max;
    logic        hold_rvalid;

    // Scoreboard reference memory and granted transfers as {we, be, word, wdata}
    logic [31:0] ref_mem [16];
    logic [40:0] sb_q [$];
    int          arr_q [$];
    int          cycle;
    int          outstanding;
    int          grants;
    int          req_start;
    int          full_cycles;
    bit          req_active;
    int          last_release;

    // Per-test expectations where -1 leaves a check off
    bit          transparent;
    int          gnt_exact;
    int          gnt_bound;
    int          rsp_exact;
    int          rsp_bound;

    perturb_top dut (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] be_merge(input logic [31:0] old, input logic [31:0] wdata,
                                             input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    // Memory latency of 0 to max cycles
    function automatic int rand_lat(input int max);
        stim_rng = xorshift(stim_rng);
        return int'(stim_rng % (max + 1));
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors so far", tests, name, errors);
        transparent = 1'b0;
        gnt_exact = -1;
        gnt_bound = -1;
        rsp_exact = -1;
        rsp_bound = -1;
    endtask

    task automatic cfg_write(input logic [2:0] addr, input logic [31:0] data);
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
        cfg_we_i    = 1'b1;
        @(posedge clk_i);
        #1;
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_read(input logic [2:0] addr, output logic [31:0] data);
        cfg_addr_i = addr;
        @(posedge clk_i);
        data = cfg_rdata_o;
        #1;
    endtask

    // One random transfer that optionally waits for its response
    task automatic do_transfer(input bit serial);
        int n;
        stim_rng     = xorshift(stim_rng);
        core_addr_i  = {26'd0, stim_rng[3:0], 2'b00};
        core_we_i    = stim_rng[4];
        core_be_i    = stim_rng[8:5];
        stim_rng     = xorshift(stim_rng);
        core_wdata_i = stim_rng;
        core_req_i   = 1'b1;
        n = 0;
        // Request and fields stay steady until the grant
        do begin
            @(posedge clk_i);
            n++;
        end while (!core_gnt_o && n < wait_limit);
        if (!core_gnt_o) abort_run("core_gnt_o");
        #1;
        core_req_i = 1'b0;
        n = 0;
        while (serial && sb_q.size() != 0 && n < wait_limit) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (serial && sb_q.size() != 0) abort_run("core_rvalid_o of a single transfer");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (sb_q.size() != 0 && n < wait_limit) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (sb_q.size() != 0) abort_run("outstanding responses to drain");
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : memory_model
        logic       held;
        logic [3:0] idx;
        held = hold_rvalid;
        if (!rst_n_i) begin
            mrsp_q.delete();
            mwait_q.delete();
            gnt_wait = 0;
        end else begin
            if (mem_req_o && mem_gnt_i) begin
                // Read data is taken before the write of the same transfer
                idx = mem_addr_o[5:2];
                mrsp_q.push_back(mem[idx]);
                mwait_q.push_back(rand_lat(rsp_lat_max));
                if (mem_we_o) mem[idx] = be_merge(mem[idx], mem_wdata_o, mem_be_o);
                gnt_wait = rand_lat(gnt_lat_max);
            end else if (gnt_wait != 0) begin
                // Grant latency runs from the previous grant
                gnt_wait--;
            end
            if (mem_rvalid_i) begin
                void'(mrsp_q.pop_front());
                void'(mwait_q.pop_front());
            end else if (mwait_q.size() != 0 && mwait_q[0] != 0 && !held) begin
                mwait_q[0]--;
            end
        end
        #1;
        mem_gnt_i    = (gnt_wait == 0);
        mem_rvalid_i = !held && mwait_q.size() != 0 && mwait_q[0] == 0;
        mem_rdata_i  = (mrsp_q.size() != 0) ? mrsp_q[0] : '0;
    end

    ////////////////////////////////////////////////////////////
    // Scoreboard and delay measurement
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : monitor
        int          gdelay;
        int          rdelay;
        int          start;
        logic [40:0] ent;
        if (!rst_n_i) begin
            cycle = 0;
            outstanding = 0;
            req_active = 1'b0;
            last_release = 0;
        end else begin
            cycle++;
            // No stall at all, only the outstanding limit gates the request
            if (transparent) begin
                check("mem_req_o", mem_req_o,
                      core_req_i && (outstanding < perturb_pkg::RESP_DEPTH));
                check("core_gnt_o", core_gnt_o,
                      core_req_i && (outstanding < perturb_pkg::RESP_DEPTH) && mem_gnt_i);
            end
            // Request fields reach memory unchanged
            if (mem_req_o) begin
                check("mem_addr_o", mem_addr_o, core_addr_i);
                check("mem_we_o", mem_we_o, core_we_i);
                check("mem_be_o", mem_be_o, core_be_i);
                check("mem_wdata_o", mem_wdata_o, core_wdata_i);
            end
            if (core_req_i && !req_active) begin
                req_active = 1'b1;
                req_start = cycle;
                full_cycles = 0;
            end
            // Cycles lost to the outstanding limit are not injected stalls
            if (req_active && outstanding == perturb_pkg::RESP_DEPTH) full_cycles++;
            if (core_gnt_o) begin
                gdelay = cycle - req_start - full_cycles;
                req_active = 1'b0;
                grants++;
                if (gnt_exact >= 0) check("grant delay", gdelay, gnt_exact);
                if (gnt_bound >= 0) check("grant delay", gdelay,
                                          (gdelay <= gnt_bound) ? gdelay : gnt_bound);
                sb_q.push_back({core_we_i, core_be_i, core_addr_i[5:2], core_wdata_i});
            end
            if (mem_rvalid_i) arr_q.push_back(cycle);
            if (core_rvalid_o) begin
                // Stall starts when the entry reaches the FIFO head
                start = arr_q.pop_front();
                if (last_release > start) start = last_release;
                rdelay = cycle - start;
                last_release = cycle;
                if (rsp_exact >= 0) check("response delay", rdelay, rsp_exact);
                if (rsp_bound >= 0) check("response delay", rdelay,
                                          (rdelay <= rsp_bound) ? rdelay : rsp_bound);
                // Writes update the reference copy, reads compare against it
                ent = sb_q.pop_front();
                if (ent[40]) begin
                    ref_mem[ent[35:32]] = be_merge(ref_mem[ent[35:32]], ent[31:0], ent[39:36]);
                end else begin
                    check("core_rdata_o", core_rdata_o, ref_mem[ent[35:32]]);
                end
            end
            if (core_gnt_o && !core_rvalid_o) outstanding++;
            if (core_rvalid_o && !core_gnt_o) outstanding--;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] val;
        logic [31:0] got;
        logic [31:0] exp;
        int          g0;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        core_req_i = 1'b0;
        core_addr_i = '0;
        core_we_i = 1'b0;
        core_be_i = '0;
        core_wdata_i = '0;
        mem_gnt_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        hold_rvalid = 1'b0;
        gnt_lat_max = 3;
        rsp_lat_max = 3;
        transparent = 1'b0;
        gnt_exact = -1;
        gnt_bound = -1;
        rsp_exact = -1;
        rsp_bound = -1;
        // Fill pattern spread over the byte address
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i * 4) * 32'h9E37_79B9 ^ 32'h5A5A_0000;
            ref_mem[i] = mem[i];
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Every register masked to its width, unmapped ones read zero
        for (int a = 0; a < 8; a++) begin
            stim_rng = xorshift(stim_rng);
            val = stim_rng;
            cfg_write(a[2:0], val);
            cfg_read(a[2:0], got);
            case (a)
                0:       exp = val & 32'h3;
                1, 2, 3: exp = val & 32'hFF;
                4:       exp = val & 32'hFFFF;
                default: exp = '0;
            endcase
            check($sformatf("cfg_rdata_o at address %0d", a), got, exp);
        end
        cfg_write(perturb_pkg::CFG_CTRL, 32'd0);
        end_test("register readback");

        transparent = 1'b1;
        rsp_exact = 1;
        repeat (200) do_transfer(1'b0);
        wait_drain();
        end_test("transparent mode");

        // Fixed grant stall against a memory that grants at once
        stim_rng = xorshift(stim_rng);
        gnt_exact = int'(stim_rng % 8);
        cfg_write(perturb_pkg::CFG_GNT, gnt_exact);
        cfg_write(perturb_pkg::CFG_RVALID, 32'd0);
        cfg_write(perturb_pkg::CFG_CTRL, 32'd1);
        gnt_lat_max = 0;
        rsp_lat_max = 0;
        repeat (40) do_transfer(1'b0);
        wait_drain();
        end_test("fixed grant stall");

        // Fixed response stall M gives M+1 cycles with one transfer in flight
        stim_rng = xorshift(stim_rng);
        rsp_exact = int'(stim_rng % 8) + 1;
        cfg_write(perturb_pkg::CFG_GNT, 32'd0);
        cfg_write(perturb_pkg::CFG_RVALID, rsp_exact - 1);
        gnt_lat_max = 3;
        rsp_lat_max = 3;
        repeat (40) do_transfer(1'b1);
        end_test("fixed response stall");

        stim_rng = xorshift(stim_rng);
        gnt_bound = int'(stim_rng % 6);
        rsp_bound = gnt_bound + 1;
        cfg_write(perturb_pkg::CFG_MAX, gnt_bound);
        cfg_write(perturb_pkg::CFG_SEED, xorshift(stim_rng));
        cfg_write(perturb_pkg::CFG_CTRL, 32'd3);
        gnt_lat_max = 0;
        repeat (200) do_transfer(1'b0);
        wait_drain();
        end_test("random mode bound");

        // Memory holds every response while the core keeps requesting
        cfg_write(perturb_pkg::CFG_CTRL, 32'd0);
        hold_rvalid = 1'b1;
        g0 = grants;
        fork
            repeat (8) do_transfer(1'b0);
            begin
                repeat (30) @(posedge clk_i);
                #1;
                check("grants before first response", grants - g0, perturb_pkg::RESP_DEPTH);
                hold_rvalid = 1'b0;
            end
        join
        wait_drain();
        end_test("outstanding limit");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb.f
source/perturb_pkg.sv
source/stall_cfg_regs.sv
source/stall_lfsr.sv
source/stall_injector.sv
source/perturb_top.sv
test/perturb_sva.sv
test/tb_perturb.sv

// File: Bender.yml
package:
  name: perturb

sources:
  - files:
      - source/perturb_pkg.sv
      - source/stall_cfg_regs.sv
      - source/stall_lfsr.sv
      - source/stall_injector.sv
      - source/perturb_top.sv
  - target: test
    files:
      - test/perturb_sva.sv
      - test/tb_perturb.sv
